/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP ?= mipsCpuTb
FLIST ?= flist.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* flist.f */
hw/mipsIsaPkg.sv
hw/mipsCtrlPkg.sv
hw/mipsControl.sv
hw/mipsAluControl.sv
hw/mipsAlu.sv
hw/mipsRegFile.sv
hw/mipsCpu.sv
test/clockGen.sv
test/mipsCpu_chk.sv
test/mipsCpuTb.sv

/* hw/mipsAlu.sv */
`default_nettype none

module mipsAlu (
	input mipsIsaPkg::word a,
	input mipsIsaPkg::word b,
	input logic [4:0] shamt,
	input mipsCtrlPkg::aluFnE aluFn,
	output mipsIsaPkg::word result,
	output logic zero
);

	// Shifts and lui work on operand b, as rt or the immediate feeds it.
	always_comb begin
		case (aluFn)
		mipsCtrlPkg::aluAdd: result = a + b;
		mipsCtrlPkg::aluSub: result = a - b;
		mipsCtrlPkg::aluAnd: result = a & b;
		mipsCtrlPkg::aluOr: result = a | b;
		mipsCtrlPkg::aluXor: result = a ^ b;
		mipsCtrlPkg::aluSlt: result = {31'b0, $signed(a) < $signed(b)};
		mipsCtrlPkg::aluSltu: result = {31'b0, a < b};
		mipsCtrlPkg::aluSll: result = b << shamt;
		mipsCtrlPkg::aluSrl: result = b >> shamt;
		mipsCtrlPkg::aluSra: result = $signed(b) >>> shamt;
		mipsCtrlPkg::aluLui: result = {b[15:0], 16'h0000};
		default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* hw/mipsAluControl.sv */
`default_nettype none

module mipsAluControl (
	input mipsCtrlPkg::aluOpE aluOp,
	input mipsIsaPkg::instrWord instr,
	output mipsCtrlPkg::aluFnE aluFn,
	output logic signExt,
	output logic shiftVar
);

	always_comb begin
		aluFn = mipsCtrlPkg::aluAdd;
		case (aluOp)
		mipsCtrlPkg::aluOpCmp: aluFn = mipsCtrlPkg::aluSub;
		mipsCtrlPkg::aluOpFunct: begin
			case (instr.rType.funct)
			mipsIsaPkg::functSubu: aluFn = mipsCtrlPkg::aluSub;
			mipsIsaPkg::functAnd: aluFn = mipsCtrlPkg::aluAnd;
			mipsIsaPkg::functOr: aluFn = mipsCtrlPkg::aluOr;
			mipsIsaPkg::functXor: aluFn = mipsCtrlPkg::aluXor;
			mipsIsaPkg::functSlt: aluFn = mipsCtrlPkg::aluSlt;
			mipsIsaPkg::functSltu: aluFn = mipsCtrlPkg::aluSltu;
			mipsIsaPkg::functSll, mipsIsaPkg::functSllv: aluFn = mipsCtrlPkg::aluSll;
			mipsIsaPkg::functSrl, mipsIsaPkg::functSrlv: aluFn = mipsCtrlPkg::aluSrl;
			mipsIsaPkg::functSra, mipsIsaPkg::functSrav: aluFn = mipsCtrlPkg::aluSra;
			default: aluFn = mipsCtrlPkg::aluAdd;
			endcase
		end
		mipsCtrlPkg::aluOpImm: begin
			case (instr.iType.opcode)
			mipsIsaPkg::opSlti: aluFn = mipsCtrlPkg::aluSlt;
			mipsIsaPkg::opSltiu: aluFn = mipsCtrlPkg::aluSltu;
			mipsIsaPkg::opAndi: aluFn = mipsCtrlPkg::aluAnd;
			mipsIsaPkg::opOri: aluFn = mipsCtrlPkg::aluOr;
			mipsIsaPkg::opLui: aluFn = mipsCtrlPkg::aluLui;
			default: aluFn = mipsCtrlPkg::aluAdd;
			endcase
		end
		default: ;
		endcase
	end

	// The logical immediates are zero-extended. sltiu still sign-extends.
	assign signExt = !(instr.iType.opcode inside {mipsIsaPkg::opAndi, mipsIsaPkg::opOri});

	assign shiftVar = (aluOp == mipsCtrlPkg::aluOpFunct) &&
		(instr.rType.funct inside {mipsIsaPkg::functSllv, mipsIsaPkg::functSrlv,
		mipsIsaPkg::functSrav});

endmodule

`default_nettype wire

/* hw/mipsControl.sv */
`default_nettype none

module mipsControl (
	input mipsIsaPkg::instrWord instr,
	output logic regDst,
	output logic jump,
	output logic branch,
	output logic memRead,
	output logic memWrite,
	output logic memToReg,
	output logic regWrite,
	output logic aluSrc,
	output mipsCtrlPkg::aluOpE aluOp
);

	// Bit order is regDst, jump, branch, memRead, memWrite, memToReg, regWrite, aluSrc.
	logic [7:0] ctrl;

	assign {regDst, jump, branch, memRead, memWrite, memToReg, regWrite, aluSrc} = ctrl;

	// Anything not listed keeps the all-zero word and retires as a no-op.
	always_comb begin
		ctrl = 8'b0000_0000;
		aluOp = mipsCtrlPkg::aluOpAddr;
		case (instr.rType.opcode)
		mipsIsaPkg::opSpecial: begin
			case (instr.rType.funct)
			mipsIsaPkg::functAddu, mipsIsaPkg::functSubu,
			mipsIsaPkg::functAnd, mipsIsaPkg::functOr, mipsIsaPkg::functXor,
			mipsIsaPkg::functSlt, mipsIsaPkg::functSltu,
			mipsIsaPkg::functSll, mipsIsaPkg::functSrl, mipsIsaPkg::functSra,
			mipsIsaPkg::functSllv, mipsIsaPkg::functSrlv, mipsIsaPkg::functSrav: begin
				ctrl = 8'b1000_0010;
				aluOp = mipsCtrlPkg::aluOpFunct;
			end
			mipsIsaPkg::functJr: ctrl = 8'b0100_0000;
			mipsIsaPkg::functJalr: ctrl = 8'b1100_0010;
			default: ;
			endcase
		end
		mipsIsaPkg::opRegimm: begin
			case (instr.iType.rt)
			mipsIsaPkg::regimmBltz, mipsIsaPkg::regimmBgez: begin
				ctrl = 8'b0010_0000;
				aluOp = mipsCtrlPkg::aluOpCmp;
			end
			default: ;
			endcase
		end
		mipsIsaPkg::opBeq, mipsIsaPkg::opBne, mipsIsaPkg::opBlez, mipsIsaPkg::opBgtz: begin
			ctrl = 8'b0010_0000;
			aluOp = mipsCtrlPkg::aluOpCmp;
		end
		mipsIsaPkg::opJ: ctrl = 8'b0100_0000;
		mipsIsaPkg::opJal: ctrl = 8'b0100_0010;
		mipsIsaPkg::opAddiu, mipsIsaPkg::opSlti, mipsIsaPkg::opSltiu,
		mipsIsaPkg::opAndi, mipsIsaPkg::opOri, mipsIsaPkg::opLui: begin
			ctrl = 8'b0000_0011;
			aluOp = mipsCtrlPkg::aluOpImm;
		end
		mipsIsaPkg::opLw: ctrl = 8'b0001_0111;
		mipsIsaPkg::opSw: ctrl = 8'b0000_1001;
		default: ;
		endcase
	end

endmodule

`default_nettype wire

/* hw/mipsCpu.sv */
`default_nettype none

module mipsCpu #(
	parameter mipsIsaPkg::word pcReset = 32'h0000_0000
) (
	input logic clk,
	input logic rst,
	output mipsIsaPkg::word fetchPc,
	input mipsIsaPkg::instrWord instr,
	input logic instrValid,
	output mipsIsaPkg::word dmemAddr,
	output mipsIsaPkg::word dmemWrData,
	output logic dmemWrite,
	output logic dmemRead,
	input mipsIsaPkg::word dmemRdData,
	output logic retireValid,
	output mipsIsaPkg::word retirePc,
	output mipsIsaPkg::instrWord retireInstr,
	output logic retireRegWrite,
	output mipsIsaPkg::regIdx retireReg,
	output mipsIsaPkg::word retireData
);

	mipsIsaPkg::word pc;
	mipsIsaPkg::word pcPlus4;
	mipsIsaPkg::word nextPc;
	mipsIsaPkg::word branchTarget;
	mipsIsaPkg::word jumpTarget;
	mipsIsaPkg::word rsData;
	mipsIsaPkg::word rtData;
	mipsIsaPkg::word immExt;
	mipsIsaPkg::word aluB;
	mipsIsaPkg::word aluResult;
	mipsIsaPkg::word writeData;
	mipsIsaPkg::regIdx writeReg;
	logic [4:0] shamt;
	logic fire;
	logic regDst, jump, branch, memRead, memWrite, memToReg, regWrite, aluSrc;
	logic signExt, shiftVar, aluZero, rsZero, taken;
	mipsCtrlPkg::aluOpE aluOp;
	mipsCtrlPkg::aluFnE aluFn;

	// Nothing executes while reset is held, so no store can reach the data memory.
	assign fire = instrValid & ~rst;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= pcReset;
		end else if (instrValid) begin
			pc <= nextPc;
		end
	end

	mipsControl i_mipsControl (
		.instr(instr), .regDst(regDst), .jump(jump), .branch(branch),
		.memRead(memRead), .memWrite(memWrite), .memToReg(memToReg),
		.regWrite(regWrite), .aluSrc(aluSrc), .aluOp(aluOp)
	);

	mipsAluControl i_mipsAluControl (
		.aluOp(aluOp), .instr(instr), .aluFn(aluFn), .signExt(signExt), .shiftVar(shiftVar)
	);

	mipsRegFile i_mipsRegFile (
		.clk(clk), .rst(rst), .raddrA(instr.rType.rs), .raddrB(instr.rType.rt),
		.waddr(writeReg), .wen(fire & regWrite), .wdata(writeData),
		.rdataA(rsData), .rdataB(rtData)
	);

	assign immExt = {{16{signExt & instr.iType.imm[15]}}, instr.iType.imm};
	assign aluB = aluSrc ? immExt : rtData;
	assign shamt = shiftVar ? rsData[4:0] : instr.rType.shamt;

	mipsAlu i_mipsAlu (
		.a(rsData), .b(aluB), .shamt(shamt), .aluFn(aluFn), .result(aluResult), .zero(aluZero)
	);

	// beq and bne use the ALU difference. The other branches test rs against zero.
	assign rsZero = (rsData == '0);

	always_comb begin
		case (instr.iType.opcode)
		mipsIsaPkg::opBeq: taken = aluZero;
		mipsIsaPkg::opBne: taken = !aluZero;
		mipsIsaPkg::opBlez: taken = rsData[31] | rsZero;
		mipsIsaPkg::opBgtz: taken = !rsData[31] & !rsZero;
		mipsIsaPkg::opRegimm: taken = (instr.iType.rt == mipsIsaPkg::regimmBgez) ?
			!rsData[31] : rsData[31];
		default: taken = 1'b0;
		endcase
	end

	assign pcPlus4 = pc + 32'd4;
	assign branchTarget = pcPlus4 + {{14{instr.iType.imm[15]}}, instr.iType.imm, 2'b00};
	assign jumpTarget = (instr.rType.opcode == mipsIsaPkg::opSpecial) ? rsData :
		{pcPlus4[31:28], instr.jType.target, 2'b00};
	assign nextPc = jump ? jumpTarget : (branch && taken) ? branchTarget : pcPlus4;

	// jal links to r31 and jalr links to rd. Both write back the return address.
	assign writeReg = (jump && !regDst) ? mipsCtrlPkg::linkReg :
		regDst ? instr.rType.rd : instr.rType.rt;
	assign writeData = jump ? pcPlus4 : memToReg ? dmemRdData : aluResult;

	assign fetchPc = pc;
	assign dmemAddr = aluResult;
	assign dmemWrData = rtData;
	assign dmemWrite = fire & memWrite;
	assign dmemRead = fire & memRead;

	assign retireValid = fire;
	assign retirePc = pc;
	assign retireInstr = instr;
	assign retireRegWrite = fire & regWrite;
	assign retireReg = writeReg;
	assign retireData = writeData;

endmodule

`default_nettype wire

/* hw/mipsCtrlPkg.sv */
`default_nettype none

package mipsCtrlPkg;

	// Operation class handed from the main decoder to the ALU decoder.
	typedef enum logic [1:0] {
		aluOpAddr  = 2'b00,
		aluOpCmp   = 2'b01,
		aluOpFunct = 2'b10,
		aluOpImm   = 2'b11
	} aluOpE;

	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluAnd  = 4'd2,
		aluOr   = 4'd3,
		aluXor  = 4'd4,
		aluSlt  = 4'd5,
		aluSltu = 4'd6,
		aluSll  = 4'd7,
		aluSrl  = 4'd8,
		aluSra  = 4'd9,
		aluLui  = 4'd10
	} aluFnE;

	localparam mipsIsaPkg::regIdx linkReg = 5'd31;

endpackage

`default_nettype wire

/* hw/mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

	typedef logic [31:0] word;
	typedef logic [4:0] regIdx;

	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opRegimm  = 6'h01,
		opJ       = 6'h02,
		opJal     = 6'h03,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opBlez    = 6'h06,
		opBgtz    = 6'h07,
		opAddiu   = 6'h09,
		opSlti    = 6'h0a,
		opSltiu   = 6'h0b,
		opAndi    = 6'h0c,
		opOri     = 6'h0d,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeE;

	typedef enum logic [5:0] {
		functSll  = 6'h00,
		functSrl  = 6'h02,
		functSra  = 6'h03,
		functSllv = 6'h04,
		functSrlv = 6'h06,
		functSrav = 6'h07,
		functJr   = 6'h08,
		functJalr = 6'h09,
		functAddu = 6'h21,
		functSubu = 6'h23,
		functAnd  = 6'h24,
		functOr   = 6'h25,
		functXor  = 6'h26,
		functSlt  = 6'h2a,
		functSltu = 6'h2b
	} functE;

	// Branch selector carried in the rt field of REGIMM instructions.
	typedef enum logic [4:0] {
		regimmBltz = 5'h00,
		regimmBgez = 5'h01
	} regimmE;

	typedef union packed {
		struct packed {
			opcodeE opcode;
			regIdx rs;
			regIdx rt;
			regIdx rd;
			logic [4:0] shamt;
			functE funct;
		} rType;
		struct packed {
			opcodeE opcode;
			regIdx rs;
			regIdx rt;
			logic [15:0] imm;
		} iType;
		struct packed {
			opcodeE opcode;
			logic [25:0] target;
		} jType;
	} instrWord;

endpackage

`default_nettype wire

/* hw/mipsRegFile.sv */
`default_nettype none

module mipsRegFile (
	input logic clk,
	input logic rst,
	input mipsIsaPkg::regIdx raddrA,
	input mipsIsaPkg::regIdx raddrB,
	input mipsIsaPkg::regIdx waddr,
	input logic wen,
	input mipsIsaPkg::word wdata,
	output mipsIsaPkg::word rdataA,
	output mipsIsaPkg::word rdataB
);

	// Register 0 has no storage at all.
	mipsIsaPkg::word regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdataA = (raddrA == 5'd0) ? '0 : regs[raddrA];
	assign rdataB = (raddrB == 5'd0) ? '0 : regs[raddrB];

endmodule

`default_nettype wire

/* test/clockGen.sv */
`default_nettype none

module clockGen #(
	parameter int resetCycles = 10
) (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset drops on a rising edge, like every other driven input.
	initial begin
		rst <= 1'b1;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* test/mipsCpuTb.sv */
`default_nettype none

module mipsCpuTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int memDepth = 256;
	localparam int instrCount = 2000;
	localparam int resetCycles = 10;
	localparam int cycleLimit = instrCount * 2 + resetCycles;
	localparam logic [31:0] seed = 32'h15f0_00a9;

	typedef struct packed {
		mipsIsaPkg::word pc;
		mipsIsaPkg::instrWord instr;
		logic regWrite;
		mipsIsaPkg::regIdx dest;
		mipsIsaPkg::word data;
		logic memRead;
		logic memWrite;
		mipsIsaPkg::word addr;
		mipsIsaPkg::word wdata;
	} retireRec;

	logic clk, rst, instrValid;
	logic dmemWrite, dmemRead, retireValid, retireRegWrite;
	mipsIsaPkg::word fetchPc, dmemAddr, dmemWrData, dmemRdData, retirePc, retireData;
	mipsIsaPkg::instrWord instr, retireInstr;
	mipsIsaPkg::regIdx retireReg;

	mipsIsaPkg::instrWord imem [memDepth];
	mipsIsaPkg::word dmem [memDepth];
	mipsIsaPkg::word refMem [memDepth];
	mipsIsaPkg::word refRegs [32];
	mipsIsaPkg::word refPc;
	logic [31:0] lfsr;
	int errorCount = 0;
	int checkCount = 0;
	int retired = 0;

	clockGen #(.resetCycles(resetCycles)) i_clockGen (.clk(clk), .rst(rst));

	mipsCpu #(.pcReset(32'h0000_0000)) i_mipsCpu (
		.clk(clk), .rst(rst), .fetchPc(fetchPc), .instr(instr), .instrValid(instrValid),
		.dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWrite(dmemWrite),
		.dmemRead(dmemRead), .dmemRdData(dmemRdData), .retireValid(retireValid),
		.retirePc(retirePc), .retireInstr(retireInstr), .retireRegWrite(retireRegWrite),
		.retireReg(retireReg), .retireData(retireData)
	);

	assign instr = imem[fetchPc[9:2]];
	assign dmemRdData = dmem[dmemAddr[9:2]];

	always @(posedge clk) begin
		if (dmemWrite) begin
			dmem[dmemAddr[9:2]] <= dmemWrData;
		end
	end

	function automatic logic [31:0] randBits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [5:0] pickFunct(logic [3:0] n);
		case (n)
		4'd0: return mipsIsaPkg::functSubu;
		4'd1: return mipsIsaPkg::functAnd;
		4'd2: return mipsIsaPkg::functOr;
		4'd3: return mipsIsaPkg::functXor;
		4'd4: return mipsIsaPkg::functSlt;
		4'd5: return mipsIsaPkg::functSltu;
		4'd6: return mipsIsaPkg::functSll;
		4'd7: return mipsIsaPkg::functSrl;
		4'd8: return mipsIsaPkg::functSra;
		4'd9: return mipsIsaPkg::functSllv;
		4'd10: return mipsIsaPkg::functSrlv;
		4'd11: return mipsIsaPkg::functSrav;
		default: return mipsIsaPkg::functAddu;
		endcase
	endfunction

	function automatic logic [5:0] pickImmOp(logic [2:0] n);
		case (n)
		3'd0: return mipsIsaPkg::opSlti;
		3'd1: return mipsIsaPkg::opSltiu;
		3'd2: return mipsIsaPkg::opAndi;
		3'd3: return mipsIsaPkg::opOri;
		3'd4: return mipsIsaPkg::opLui;
		default: return mipsIsaPkg::opAddiu;
		endcase
	endfunction

	// Branch targets are chosen as a word slot first, then turned into an offset.
	function automatic mipsIsaPkg::instrWord makeInstr(int slot);
		logic [4:0] kind, rs, rt, rd;
		logic [15:0] imm, off, mem;
		logic [7:0] tgt;
		logic [2:0] pick;
		kind = 5'(randBits(5));
		rs = 5'(randBits(3));
		rt = 5'(randBits(3));
		rd = 5'(randBits(3));
		imm = 16'(randBits(16));
		tgt = 8'(randBits(8));
		pick = 3'(randBits(3));
		off = 16'(int'(tgt) - slot - 1);
		mem = {6'b0, tgt, 2'b00};
		if (kind >= 5'd12 && kind < 5'd18) return {pickImmOp(pick), rs, rt, imm};
		if (kind == 5'd18 || kind == 5'd19) return {mipsIsaPkg::opLw, 5'd0, rt, mem};
		if (kind == 5'd20 || kind == 5'd21) return {mipsIsaPkg::opSw, 5'd0, rt, mem};
		if (kind >= 5'd22 && kind < 5'd26) begin
			case (pick)
			3'd1: return {mipsIsaPkg::opBne, rs, rt, off};
			3'd2: return {mipsIsaPkg::opBlez, rs, 5'd0, off};
			3'd3: return {mipsIsaPkg::opBgtz, rs, 5'd0, off};
			3'd4: return {mipsIsaPkg::opRegimm, rs, 5'd0, off};
			3'd5: return {mipsIsaPkg::opRegimm, rs, 5'd1, off};
			default: return {mipsIsaPkg::opBeq, rs, rt, off};
			endcase
		end
		if (kind == 5'd26) return {mipsIsaPkg::opJ, 18'd0, tgt};
		if (kind == 5'd27) return {mipsIsaPkg::opJal, 18'd0, tgt};
		if (kind == 5'd28) begin
			if (pick[0]) return {mipsIsaPkg::opSpecial, 15'd0, 5'd0, mipsIsaPkg::functJr};
			return {mipsIsaPkg::opSpecial, 10'd0, rd, 5'd0, mipsIsaPkg::functJalr};
		end
		// mult, lb, sb and bltzal all have to retire as no-ops.
		if (kind == 5'd29) begin
			case (pick[1:0])
			2'd0: return {mipsIsaPkg::opSpecial, rs, rt, 10'd0, 6'h18};
			2'd1: return {6'h20, 5'd0, rt, mem};
			2'd2: return {6'h28, 5'd0, rt, mem};
			default: return {mipsIsaPkg::opRegimm, rs, 5'h10, off};
			endcase
		end
		return {mipsIsaPkg::opSpecial, rs, rt, rd, 5'(randBits(5)), pickFunct(4'(randBits(4)))};
	endfunction

	function automatic retireRec withWrite(retireRec r, mipsIsaPkg::regIdx d,
		mipsIsaPkg::word v);
		r.regWrite = 1'b1;
		r.dest = d;
		r.data = v;
		return r;
	endfunction

	// Executes one instruction on the model state and returns what should retire.
	function automatic retireRec refStep(mipsIsaPkg::instrWord ins);
		retireRec r;
		mipsIsaPkg::word a, b, se, ze, pc4, next, bt, ea;
		mipsIsaPkg::regIdx d, t;
		logic [4:0] sh;
		r = '0;
		r.pc = refPc;
		r.instr = ins;
		a = refRegs[ins.rType.rs];
		b = refRegs[ins.rType.rt];
		se = {{16{ins.iType.imm[15]}}, ins.iType.imm};
		ze = {16'h0000, ins.iType.imm};
		pc4 = refPc + 32'd4;
		next = pc4;
		bt = pc4 + (se << 2);
		ea = a + se;
		d = ins.rType.rd;
		t = ins.iType.rt;
		sh = ins.rType.shamt;
		case (ins.rType.opcode)
		mipsIsaPkg::opSpecial: begin
			case (ins.rType.funct)
			mipsIsaPkg::functAddu: r = withWrite(r, d, a + b);
			mipsIsaPkg::functSubu: r = withWrite(r, d, a - b);
			mipsIsaPkg::functAnd: r = withWrite(r, d, a & b);
			mipsIsaPkg::functOr: r = withWrite(r, d, a | b);
			mipsIsaPkg::functXor: r = withWrite(r, d, a ^ b);
			mipsIsaPkg::functSlt: r = withWrite(r, d, {31'b0, $signed(a) < $signed(b)});
			mipsIsaPkg::functSltu: r = withWrite(r, d, {31'b0, a < b});
			mipsIsaPkg::functSll: r = withWrite(r, d, b << sh);
			mipsIsaPkg::functSrl: r = withWrite(r, d, b >> sh);
			mipsIsaPkg::functSra: r = withWrite(r, d, $signed(b) >>> sh);
			mipsIsaPkg::functSllv: r = withWrite(r, d, b << a[4:0]);
			mipsIsaPkg::functSrlv: r = withWrite(r, d, b >> a[4:0]);
			mipsIsaPkg::functSrav: r = withWrite(r, d, $signed(b) >>> a[4:0]);
			mipsIsaPkg::functJr: next = a;
			mipsIsaPkg::functJalr: begin
				r = withWrite(r, d, pc4);
				next = a;
			end
			default: ;
			endcase
		end
		mipsIsaPkg::opRegimm: begin
			if (t == 5'd0) begin
				if (a[31]) next = bt;
			end else if (t == 5'd1) begin
				if (!a[31]) next = bt;
			end
		end
		mipsIsaPkg::opBeq: if (a == b) next = bt;
		mipsIsaPkg::opBne: if (a != b) next = bt;
		mipsIsaPkg::opBlez: if ($signed(a) <= 0) next = bt;
		mipsIsaPkg::opBgtz: if ($signed(a) > 0) next = bt;
		mipsIsaPkg::opJ: next = {pc4[31:28], ins.jType.target, 2'b00};
		mipsIsaPkg::opJal: begin
			r = withWrite(r, mipsCtrlPkg::linkReg, pc4);
			next = {pc4[31:28], ins.jType.target, 2'b00};
		end
		mipsIsaPkg::opAddiu: r = withWrite(r, t, a + se);
		mipsIsaPkg::opSlti: r = withWrite(r, t, {31'b0, $signed(a) < $signed(se)});
		mipsIsaPkg::opSltiu: r = withWrite(r, t, {31'b0, a < se});
		mipsIsaPkg::opAndi: r = withWrite(r, t, a & ze);
		mipsIsaPkg::opOri: r = withWrite(r, t, a | ze);
		mipsIsaPkg::opLui: r = withWrite(r, t, {ins.iType.imm, 16'h0000});
		mipsIsaPkg::opLw: begin
			r = withWrite(r, t, refMem[ea[9:2]]);
			r.memRead = 1'b1;
		end
		mipsIsaPkg::opSw: begin
			r.memWrite = 1'b1;
			r.addr = ea;
			r.wdata = b;
			refMem[ea[9:2]] = b;
		end
		default: ;
		endcase
		if (r.regWrite && r.dest != 5'd0) refRegs[r.dest] = r.data;
		refPc = next;
		return r;
	endfunction

	task automatic compareWord(string name, mipsIsaPkg::word got, mipsIsaPkg::word want);
		checkCount++;
		if (got !== want) begin
			errorCount++;
			$display("FAIL %s got %h expected %h", name, got, want);
		end
	endtask

	task automatic compareBit(string name, logic got, logic want);
		checkCount++;
		if (got !== want) begin
			errorCount++;
			$display("FAIL %s got %h expected %h", name, got, want);
		end
	endtask

	task automatic comparePc(mipsIsaPkg::word got, mipsIsaPkg::word want);
		checkCount++;
		if (got !== want) begin
			errorCount++;
			$display("FAIL retirePc got %h expected %h", got, want);
		end
	endtask

	task automatic compareInstr(mipsIsaPkg::instrWord got, mipsIsaPkg::instrWord want);
		checkCount++;
		if (got !== want) begin
			errorCount++;
			$display("FAIL retireInstr got %h expected %h", got, want);
		end
	endtask

	task automatic compareReg(mipsIsaPkg::regIdx got, logic gotWr, mipsIsaPkg::regIdx want,
		logic wantWr);
		checkCount++;
		if (gotWr !== wantWr) begin
			errorCount++;
			$display("FAIL retireRegWrite got %h expected %h", gotWr, wantWr);
		end else if (wantWr && got !== want) begin
			errorCount++;
			$display("FAIL retireReg got %h expected %h", got, want);
		end
	endtask

	// About one cycle in eight stalls the core.
	always @(posedge clk) begin
		instrValid <= (3'(randBits(3)) != 3'd0);
	end

	always @(posedge clk) begin
		retireRec want;
		if (!rst) begin
			compareBit("retireValid", retireValid, instrValid);
		end
		if (!rst && retireValid) begin
			want = refStep(imem[refPc[9:2]]);
			comparePc(retirePc, want.pc);
			compareInstr(retireInstr, want.instr);
			compareReg(retireReg, retireRegWrite, want.dest, want.regWrite);
			if (want.regWrite) compareWord("retireData", retireData, want.data);
			compareBit("dmemWrite", dmemWrite, want.memWrite);
			compareBit("dmemRead", dmemRead, want.memRead);
			if (want.memWrite) begin
				compareWord("dmemAddr", dmemAddr, want.addr);
				compareWord("dmemWrData", dmemWrData, want.wdata);
			end
			retired++;
		end else if (!rst && (dmemWrite || dmemRead || retireRegWrite)) begin
			errorCount++;
			$display("A strobe was active in a cycle that retired nothing.");
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		instrValid <= 1'b0;
		lfsr = seed;
		for (int i = 0; i < memDepth - 1; i++) begin
			imem[i] = makeInstr(i);
		end
		imem[memDepth - 1] = {mipsIsaPkg::opJ, 26'd0};
		for (int i = 0; i < memDepth; i++) begin
			refMem[i] = randBits(32);
			dmem[i] <= refMem[i];
		end
		for (int i = 0; i < 32; i++) begin
			refRegs[i] = '0;
		end
		refPc = 32'h0000_0000;
		while (retired < instrCount && cycles < cycleLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (retired < instrCount) begin
			errorCount++;
			$display("Timeout after %0d cycles with %0d instructions retired.", cycles, retired);
		end
		$display("Retired %0d, checks %0d, errors %0d", retired, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/mipsCpu_chk.sv */
`default_nettype none

module mipsCpu_chk (
	input logic clk,
	input logic rst,
	input mipsIsaPkg::word fetchPc,
	input logic instrValid,
	input logic dmemRead,
	input logic dmemWrite,
	input logic retireValid,
	input logic retireRegWrite
);

	timeunit 1ns;
	timeprecision 100ps;

	noRetireInReset: assert property (@(posedge clk) rst |-> !retireValid)
		else $error("retireValid high during reset");

	pcAligned: assert property (@(posedge clk) disable iff (rst) fetchPc[1:0] == 2'b00)
		else $error("fetchPc is not word-aligned");

	oneStrobe: assert property (@(posedge clk) !(dmemRead && dmemWrite))
		else $error("dmemRead and dmemWrite both high");

	quietWhenInvalid: assert property (@(posedge clk)
		!instrValid |-> !(dmemRead || dmemWrite || retireRegWrite))
		else $error("strobe high without a valid instruction");

	// A stalled cycle must leave the fetch address where it was.
	pcHeld: assert property (@(posedge clk) (!instrValid && !rst) |=> $stable(fetchPc))
		else $error("fetchPc moved across a stall");

endmodule

bind mipsCpu mipsCpu_chk i_mipsCpu_chk (
	.clk(clk), .rst(rst), .fetchPc(fetchPc), .instrValid(instrValid),
	.dmemRead(dmemRead), .dmemWrite(dmemWrite), .retireValid(retireValid),
	.retireRegWrite(retireRegWrite)
);

`default_nettype wire
